//--- ChecksumFramer.f
+incdir+common
+incdir+bench
common/FrameTypes.sv
common/ChecksumTypes.sv
fletcher/FletcherAccum.sv
fletcher/TrailerHold.sv
logic/ChecksumVerifier.sv
logic/FrameControl.sv
logic/ChecksumFramer.sv
bench/ChecksumFramerTb.sv

//--- bench/frameModel.svh
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

// a frame as a plain list of 16 bit words
typedef logic [`FLETCHER_HALF-1:0] wordList[$];

// a sums the words, b sums the a values, both mod 65535
function automatic checksumTypes::fletcherSum modelSum(input wordList words);
    int a;
    int b;
    checksumTypes::fletcherSum s;
    a = 0;
    b = 0;
    foreach (words[i]) begin
        a = (a + int'(words[i])) % 65535;
        b = (b + a) % 65535;
    end
    s.b = b[`FLETCHER_HALF-1:0];
    s.a = a[`FLETCHER_HALF-1:0];
    return s;
endfunction

// 0xffff and 0 name the same residue
function automatic logic [`FLETCHER_HALF-1:0] modReduce(input logic [`FLETCHER_HALF-1:0] x);
    int v;
    v = int'(x) % 65535;
    return v[`FLETCHER_HALF-1:0];
endfunction

// payload, then b, then a
function automatic wordList withTrailer(input wordList payload);
    wordList frame;
    checksumTypes::fletcherSum s;
    s = modelSum(payload);
    frame = payload;
    frame.push_back(s.b);
    frame.push_back(s.a);
    return frame;
endfunction

`endif

//--- bench/ChecksumFramerTb.sv
`timescale 1ns/10ps

`include "fletcher_settings.svh"

module ChecksumFramerTb;

    `include "frameModel.svh"

    logic clk;
    logic rst;
    logic inStrobe;
    frameTypes::streamWord inWord;
    frameTypes::frameMode mode;
    logic outStrobe;
    frameTypes::streamWord outWord;
    logic resultStrobe;
    checksumTypes::verifyResult result;

    int seed;
    int cycle = 0;
    int checks = 0;
    int errors = 0;
    string testName = "reset";

    // scoreboard, each item with the cycle it is due in
    int wordDue[$];
    frameTypes::streamWord wordExp[$];
    int resultDue[$];
    checksumTypes::verifyResult resultExp[$];
    // short frames only compare ok, shortFrame and payloadWords
    logic resultFull[$];

    ChecksumFramer uut (
        .clk          (clk),
        .rst          (rst),
        .inStrobe     (inStrobe),
        .inWord       (inWord),
        .mode         (mode),
        .outStrobe    (outStrobe),
        .outWord      (outWord),
        .resultStrobe (resultStrobe),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // random words, low is or'ed in to force large values
    function automatic wordList randomWords(input int len, input int low);
        wordList q;
        int v;
        for (int i = 0; i < len; i++) begin
            v = $random(seed);
            q.push_back(`FLETCHER_HALF'(low | v));
        end
        return q;
    endfunction

    task automatic checkWord();
        logic late;
        late = !outStrobe && wordDue.size() > 0 && wordDue[0] <= cycle;
        assert (!late) else begin
            $display("outStrobe never came for the word due at cycle %0d in %s",
                     wordDue[0], testName);
            errors++;
        end
        if (late) begin
            void'(wordDue.pop_front());
            void'(wordExp.pop_front());
        end
        if (outStrobe) begin
            checks++;
            assert (wordDue.size() > 0) else begin
                $display("outStrobe fired with no word expected at cycle %0d in %s",
                         cycle, testName);
                errors++;
            end
            if (wordDue.size() > 0) begin
                assert (wordDue[0] == cycle) else begin
                    $display("CHECK FAILED %s outStrobe cycle expected %0d actual %0d",
                             testName, wordDue[0], cycle);
                    errors++;
                end
                assert (outWord == wordExp[0]) else begin
                    $display("CHECK FAILED %s outWord expected %h actual %h",
                             testName, wordExp[0], outWord);
                    errors++;
                end
                void'(wordDue.pop_front());
                void'(wordExp.pop_front());
            end
        end
    endtask

    task automatic checkResult();
        logic late;
        logic match;
        checksumTypes::verifyResult want;
        late = !resultStrobe && resultDue.size() > 0 && resultDue[0] <= cycle;
        assert (!late) else begin
            $display("resultStrobe never came for the result due at cycle %0d in %s",
                     resultDue[0], testName);
            errors++;
        end
        if (late) begin
            void'(resultDue.pop_front());
            void'(resultExp.pop_front());
            void'(resultFull.pop_front());
        end
        if (resultStrobe) begin
            checks++;
            assert (resultDue.size() > 0) else begin
                $display("resultStrobe fired with no result expected at cycle %0d in %s",
                         cycle, testName);
                errors++;
            end
            if (resultDue.size() > 0) begin
                want = resultExp[0];
                // sums of a short frame carry no meaning
                match = resultFull[0] ? (result == want) :
                        ({result.ok, result.shortFrame, result.payloadWords} ==
                         {want.ok, want.shortFrame, want.payloadWords});
                assert (resultDue[0] == cycle) else begin
                    $display("CHECK FAILED %s resultStrobe cycle expected %0d actual %0d",
                             testName, resultDue[0], cycle);
                    errors++;
                end
                assert (match) else begin
                    $display("CHECK FAILED %s result expected %h actual %h",
                             testName, want, result);
                    errors++;
                end
                void'(resultDue.pop_front());
                void'(resultExp.pop_front());
                void'(resultFull.pop_front());
            end
        end
    endtask

    // all outputs are registered, so they are settled at the falling edge
    always @(negedge clk) begin
        checkWord();
        checkResult();
    end

    // drive one frame and queue what it should produce
    task automatic sendFrame(input wordList words, input frameTypes::frameMode m);
        int n;
        int t;
        frameTypes::streamWord w;
        frameTypes::streamWord fwd;
        wordList payload;
        checksumTypes::fletcherSum s;
        checksumTypes::verifyResult want;
        n = words.size();
        t = 0;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            w.data  = words[i];
            w.first = (i == 0);
            w.last  = (i == n - 1);
            inStrobe = 1'b1;
            inWord   = w;
            // wrong mode after the first word, must be ignored
            mode = (i == 0) ? m : frameTypes::frameMode'(~m);
            t = cycle;
            if (m == frameTypes::modeGenerate) begin
                w.last = 1'b0;
                wordDue.push_back(t + 1);
                wordExp.push_back(w);
            end else if (i >= 2) begin
                // word i pushes word i-2 out of the trailer store
                fwd.data  = words[i - 2];
                fwd.first = (i == 2);
                fwd.last  = (i == n - 1);
                wordDue.push_back(t + 1);
                wordExp.push_back(fwd);
            end
        end
        if (m == frameTypes::modeGenerate) begin
            s = modelSum(words);
            w.data  = s.b;
            w.first = 1'b0;
            w.last  = 1'b0;
            wordDue.push_back(t + 3);
            wordExp.push_back(w);
            w.data = s.a;
            w.last = 1'b1;
            wordDue.push_back(t + 4);
            wordExp.push_back(w);
        end else begin
            for (int i = 0; i < n - 2; i++) begin
                payload.push_back(words[i]);
            end
            want.shortFrame   = (n < 3);
            want.payloadWords = (n < 3) ? '0 : `FRAME_LEN_BITS'(n - 2);
            want.computed     = modelSum(payload);
            want.received     = '0;
            if (n >= 3) begin
                want.received.b = modReduce(words[n - 2]);
                want.received.a = modReduce(words[n - 1]);
            end
            want.ok = (n >= 3) && (want.computed == want.received);
            resultDue.push_back(t + 3);
            resultExp.push_back(want);
            resultFull.push_back(n >= 3);
        end
        @(negedge clk);
        inStrobe = 1'b0;
        inWord   = '0;
    endtask

    // wait for the frame to drain, then leave the idle gap
    task automatic waitDrained();
        int waited;
        waited = 0;
        while (wordDue.size() > 0 && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        assert (wordDue.size() == 0) else begin
            $display("timeout, outStrobe never came in %s", testName);
            errors++;
        end
        waited = 0;
        while (resultDue.size() > 0 && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        assert (resultDue.size() == 0) else begin
            $display("timeout, resultStrobe never came in %s", testName);
            errors++;
        end
        repeat (3 + ($unsigned($random(seed)) % 3)) @(negedge clk);
    endtask

    initial begin
        wordList payload;
        wordList frame;
        int idx;
        int flip;
        seed = 32'h674b;
        rst = 1'b1;
        inStrobe = 1'b0;
        inWord = '0;
        mode = frameTypes::modeGenerate;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        // quiet outputs until the first frame
        repeat (6) @(negedge clk);

        testName = "generate";
        for (int f = 0; f < 10; f++) begin
            frame = randomWords(1 + $unsigned($random(seed)) % 20, 0);
            sendFrame(frame, frameTypes::modeGenerate);
            waitDrained();
        end

        testName = "verify good";
        for (int f = 0; f < 8; f++) begin
            frame = withTrailer(randomWords(1 + $unsigned($random(seed)) % 18, 0));
            sendFrame(frame, frameTypes::modeVerify);
            waitDrained();
        end

        testName = "verify corrupt";
        for (int f = 0; f < 8; f++) begin
            frame = withTrailer(randomWords(1 + $unsigned($random(seed)) % 18, 0));
            // even frames hit the payload, odd ones the trailer
            if (f % 2 == 0) begin
                idx = $unsigned($random(seed)) % (frame.size() - 2);
            end else begin
                idx = frame.size() - 2 + $unsigned($random(seed)) % 2;
            end
            flip = $unsigned($random(seed)) % 16;
            frame[idx][flip] = ~frame[idx][flip];
            sendFrame(frame, frameTypes::modeVerify);
            waitDrained();
        end

        testName = "modular edge";
        sendFrame(randomWords(12, 'hFFFF), frameTypes::modeGenerate);
        waitDrained();
        // all ones payload sums to zero, so ffff and 0 trailers both match
        payload = randomWords(9, 'hFFFF);
        frame = payload;
        frame.push_back('hFFFF);
        frame.push_back('hFFFF);
        sendFrame(frame, frameTypes::modeVerify);
        waitDrained();
        sendFrame(withTrailer(payload), frameTypes::modeVerify);
        waitDrained();
        for (int f = 0; f < 2; f++) begin
            sendFrame(randomWords(300, 'hF000), frameTypes::modeGenerate);
            waitDrained();
            sendFrame(withTrailer(randomWords(300, 'hF000)), frameTypes::modeVerify);
            waitDrained();
        end

        testName = "short verify";
        sendFrame(randomWords(1, 0), frameTypes::modeVerify);
        waitDrained();
        sendFrame(randomWords(2, 0), frameTypes::modeVerify);
        waitDrained();

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- common/ChecksumTypes.sv
`include "fletcher_settings.svh"

package checksumTypes;

    // b is the high half, sent first as trailer
    typedef struct packed {
        logic [`FLETCHER_HALF-1:0] b;
        logic [`FLETCHER_HALF-1:0] a;
    } fletcherSum;

    // one record per verify frame
    typedef struct packed {
        logic ok;
        logic shortFrame;
        logic [`FRAME_LEN_BITS-1:0] payloadWords;
        // sum over the forwarded payload
        fletcherSum computed;
        // trailer as received, folded into 0..65534
        fletcherSum received;
    } verifyResult;

endpackage

//--- common/FrameTypes.sv
`include "fletcher_settings.svh"

package frameTypes;

    // one word on the stream, with frame delimiters
    typedef struct packed {
        logic [`FLETCHER_HALF-1:0] data;
        logic first;
        logic last;
    } streamWord;

    // sampled only together with a first word
    typedef enum logic {
        modeGenerate = 1'b0,
        modeVerify   = 1'b1
    } frameMode;

    // handed to the verifier when a verify frame has settled
    typedef struct packed {
        // fewer than three words, no payload left after the trailer
        logic shortFrame;
        logic [`FRAME_LEN_BITS-1:0] payloadWords;
    } frameEnd;

endpackage

//--- common/fletcher_settings.svh
`ifndef FLETCHER_SETTINGS_SVH
`define FLETCHER_SETTINGS_SVH

// one stream word and one checksum half
`define FLETCHER_HALF 16

// raw adder result of two halves, carry bit included
`define FLETCHER_SUM_BITS (`FLETCHER_HALF + 1)

// payload word counter
`define FRAME_LEN_BITS 16

`endif

//--- fletcher/FletcherAccum.sv
`timescale 1ns/10ps

`include "fletcher_settings.svh"

module FletcherAccum (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     accStrobe,
    input  frameTypes::streamWord    accWord,
    output checksumTypes::fletcherSum sum
);

    // running sums, always kept in 0..65534
    logic [`FLETCHER_HALF-1:0] aSum;
    logic [`FLETCHER_HALF-1:0] bSum;

    // b runs one cycle behind a
    logic accPrev;
    logic firstPrev;

    logic [`FLETCHER_HALF-1:0] aNext;
    logic [`FLETCHER_HALF-1:0] bNext;

    // ones complement add, then 0xffff folded to 0
    function automatic logic [`FLETCHER_HALF-1:0] foldAdd(
        input logic [`FLETCHER_HALF-1:0] x,
        input logic [`FLETCHER_HALF-1:0] y
    );
        logic [`FLETCHER_SUM_BITS-1:0] raw;
        logic [`FLETCHER_HALF-1:0] wrapped;
        raw = {1'b0, x} + {1'b0, y};
        // end-around carry, cannot carry out again
        wrapped = raw[`FLETCHER_HALF-1:0] + {{(`FLETCHER_HALF-1){1'b0}}, raw[`FLETCHER_HALF]};
        if (wrapped == {`FLETCHER_HALF{1'b1}}) begin
            wrapped = '0;
        end
        return wrapped;
    endfunction

    always_comb begin
        // first word of a frame restarts from zero
        if (accWord.first) begin
            aNext = foldAdd('0, accWord.data);
        end else begin
            aNext = foldAdd(aSum, accWord.data);
        end
        // b starts from the first a value of the frame
        if (firstPrev) begin
            bNext = aSum;
        end else begin
            bNext = foldAdd(bSum, aSum);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            accPrev   <= 1'b0;
            firstPrev <= 1'b0;
            aSum      <= '0;
            bSum      <= '0;
        end else begin
            accPrev   <= accStrobe;
            firstPrev <= accStrobe && accWord.first;
            // a stage
            if (accStrobe) begin
                aSum <= aNext;
            end
            // b stage sees a one cycle later
            if (accPrev) begin
                bSum <= bNext;
            end
        end
    end

    assign sum.b = bSum;
    assign sum.a = aSum;

endmodule

//--- fletcher/TrailerHold.sv
`timescale 1ns/10ps

module TrailerHold (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      holdStrobe,
    input  frameTypes::streamWord     holdIn,
    output frameTypes::streamWord     holdOut,
    output logic                      holdFull,
    output checksumTypes::fletcherSum trailer
);

    // two newest words of the frame
    frameTypes::streamWord holdOld;
    frameTypes::streamWord holdNew;

    // 0, 1 or 2 valid entries
    logic [1:0] fillCount;

    always_ff @(posedge clk) begin
        if (rst) begin
            fillCount <= 2'd0;
        end else if (holdStrobe) begin
            if (holdIn.first) begin
                fillCount <= 2'd1;
            end else if (fillCount != 2'd2) begin
                fillCount <= fillCount + 2'd1;
            end
        end
    end

    // shift in the newest word
    always_ff @(posedge clk) begin
        if (holdStrobe) begin
            holdOld <= holdNew;
            holdNew <= holdIn;
        end
    end

    // word pushed out by holdIn
    // stale when a new frame starts, so a first word is never full
    assign holdOut  = holdOld;
    assign holdFull = (fillCount == 2'd2) && !holdIn.first;

    // older word is b, newer is a
    assign trailer.b = holdOld.data;
    assign trailer.a = holdNew.data;

endmodule

//--- logic/ChecksumFramer.sv
`timescale 1ns/10ps

module ChecksumFramer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       inStrobe,
    input  frameTypes::streamWord      inWord,
    input  frameTypes::frameMode       mode,
    output logic                       outStrobe,
    output frameTypes::streamWord      outWord,
    output logic                       resultStrobe,
    output checksumTypes::verifyResult result
);

    // accumulator path
    logic accStrobe;
    frameTypes::streamWord accWord;
    checksumTypes::fletcherSum sum;

    // trailer store path
    logic holdStrobe;
    frameTypes::streamWord holdIn;
    frameTypes::streamWord holdOut;
    logic holdFull;
    checksumTypes::fletcherSum trailer;

    // verifier handoff
    logic finishStrobe;
    frameTypes::frameEnd finishInfo;

    FrameControl control (
        .clk          (clk),
        .rst          (rst),
        .inStrobe     (inStrobe),
        .inWord       (inWord),
        .mode         (mode),
        .sum          (sum),
        .holdOut      (holdOut),
        .holdFull     (holdFull),
        .accStrobe    (accStrobe),
        .accWord      (accWord),
        .holdIn       (holdIn),
        .holdStrobe   (holdStrobe),
        .finishStrobe (finishStrobe),
        .finishInfo   (finishInfo),
        .outStrobe    (outStrobe),
        .outWord      (outWord)
    );

    FletcherAccum accum (
        .clk       (clk),
        .rst       (rst),
        .accStrobe (accStrobe),
        .accWord   (accWord),
        .sum       (sum)
    );

    TrailerHold hold (
        .clk        (clk),
        .rst        (rst),
        .holdStrobe (holdStrobe),
        .holdIn     (holdIn),
        .holdOut    (holdOut),
        .holdFull   (holdFull),
        .trailer    (trailer)
    );

    ChecksumVerifier verifier (
        .clk          (clk),
        .rst          (rst),
        .finishStrobe (finishStrobe),
        .finishInfo   (finishInfo),
        .sum          (sum),
        .trailer      (trailer),
        .resultStrobe (resultStrobe),
        .result       (result)
    );

endmodule

//--- logic/ChecksumVerifier.sv
`timescale 1ns/10ps

`include "fletcher_settings.svh"

module ChecksumVerifier (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       finishStrobe,
    input  frameTypes::frameEnd        finishInfo,
    input  checksumTypes::fletcherSum  sum,
    input  checksumTypes::fletcherSum  trailer,
    output logic                       resultStrobe,
    output checksumTypes::verifyResult result
);

    checksumTypes::fletcherSum received;
    logic match;

    // 0xffff and 0 are the same value mod 65535
    function automatic logic [`FLETCHER_HALF-1:0] reduceHalf(
        input logic [`FLETCHER_HALF-1:0] x
    );
        logic [`FLETCHER_HALF-1:0] r;
        r = x;
        if (x == {`FLETCHER_HALF{1'b1}}) begin
            r = '0;
        end
        return r;
    endfunction

    always_comb begin
        received.b = reduceHalf(trailer.b);
        received.a = reduceHalf(trailer.a);
        // sum halves are already in range
        match = (received == sum);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultStrobe <= 1'b0;
        end else begin
            resultStrobe <= finishStrobe;
        end
    end

    // record loaded once per finish strobe
    always_ff @(posedge clk) begin
        if (finishStrobe) begin
            result.ok           <= match && !finishInfo.shortFrame;
            result.shortFrame   <= finishInfo.shortFrame;
            result.payloadWords <= finishInfo.payloadWords;
            result.computed     <= sum;
            result.received     <= received;
        end
    end

endmodule

//--- logic/FrameControl.sv
`timescale 1ns/10ps

`include "fletcher_settings.svh"

module FrameControl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inStrobe,
    input  frameTypes::streamWord     inWord,
    input  frameTypes::frameMode      mode,
    input  checksumTypes::fletcherSum sum,
    input  frameTypes::streamWord     holdOut,
    input  logic                      holdFull,
    output logic                      accStrobe,
    output frameTypes::streamWord     accWord,
    output frameTypes::streamWord     holdIn,
    output logic                      holdStrobe,
    output logic                      finishStrobe,
    output frameTypes::frameEnd       finishInfo,
    output logic                      outStrobe,
    output frameTypes::streamWord     outWord
);

    // trailer states name the word on outWord in that cycle
    typedef enum logic [2:0] {
        stIdle,
        stFrame,
        stSettle,
        stTrailerB,
        stTrailerA
    } ctrlState;

    ctrlState state;
    ctrlState stateNext;

    frameTypes::frameMode modeReg;
    frameTypes::frameMode activeMode;
    logic settleCnt;
    logic [`FRAME_LEN_BITS-1:0] payloadCount;

    logic startNow;
    logic wordTake;
    logic genMode;
    logic settleDone;

    logic outLoad;
    frameTypes::streamWord outNext;

    always_comb begin
        // a first word may open a frame as soon as the last trailer word is out
        startNow = inStrobe && inWord.first &&
                   (state == stIdle || state == stTrailerA || state == stFrame);
        wordTake = inStrobe && (state == stFrame || startNow);
        // mode is live on the first word, latched after that
        activeMode = startNow ? mode : modeReg;
        genMode    = (activeMode == frameTypes::modeGenerate);
        settleDone = (state == stSettle) && settleCnt;
    end

    // routing to accumulator and trailer store
    always_comb begin
        holdIn     = inWord;
        holdStrobe = wordTake && !genMode;
        // verify feeds the word displaced from the store
        accWord    = genMode ? inWord : holdOut;
        accStrobe  = wordTake && (genMode || holdFull);
    end

    // verifier handoff, sum is final in the second settle cycle
    assign finishStrobe            = settleDone && (modeReg == frameTypes::modeVerify);
    assign finishInfo.shortFrame   = (payloadCount == '0);
    assign finishInfo.payloadWords = payloadCount;

    always_comb begin
        stateNext = state;
        case (state)
            stIdle, stTrailerA: begin
                if (startNow) begin
                    stateNext = inWord.last ? stSettle : stFrame;
                end else begin
                    stateNext = stIdle;
                end
            end
            stFrame: begin
                if (wordTake && inWord.last) begin
                    stateNext = stSettle;
                end
            end
            stSettle: begin
                if (settleCnt) begin
                    stateNext = (modeReg == frameTypes::modeGenerate) ? stTrailerB : stIdle;
                end
            end
            stTrailerB: begin
                stateNext = stTrailerA;
            end
            default: begin
                stateNext = stIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= stIdle;
            settleCnt    <= 1'b0;
            modeReg      <= frameTypes::modeGenerate;
            payloadCount <= '0;
        end else begin
            state <= stateNext;
            // two settle cycles
            settleCnt <= (state == stSettle) && !settleCnt;
            if (startNow) begin
                modeReg      <= mode;
                payloadCount <= accStrobe ? `FRAME_LEN_BITS'(1) : '0;
            end else if (accStrobe) begin
                payloadCount <= payloadCount + 1'b1;
            end
        end
    end

    // next output word
    always_comb begin
        outLoad = 1'b0;
        outNext = inWord;
        if (wordTake && genMode) begin
            // payload unchanged, last moves to the trailer
            outLoad      = 1'b1;
            outNext      = inWord;
            outNext.last = 1'b0;
        end else if (wordTake && holdFull) begin
            // displaced word is final payload when the last input pushes it
            outLoad      = 1'b1;
            outNext      = holdOut;
            outNext.last = inWord.last;
        end else if (settleDone && modeReg == frameTypes::modeGenerate) begin
            outLoad       = 1'b1;
            outNext.data  = sum.b;
            outNext.first = 1'b0;
            outNext.last  = 1'b0;
        end else if (state == stTrailerB) begin
            outLoad       = 1'b1;
            outNext.data  = sum.a;
            outNext.first = 1'b0;
            outNext.last  = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= outLoad;
        end
    end

    always_ff @(posedge clk) begin
        if (outLoad) begin
            outWord <= outNext;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the ChecksumFramer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module ChecksumFramerTb \
    -f ChecksumFramer.f \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VChecksumFramerTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
